// File: src/rvPkg.sv
`default_nettype none

package rvPkg;

	// Datapath and memory geometry
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int memAddrWidth = 8;
	localparam int memDepth = 2 ** memAddrWidth;

	// First fetch address after reset, in bytes
	localparam logic [dataWidth-1:0] resetPc = 32'h0000_0000;

	// RV32I major opcodes handled by the core
	localparam logic [6:0] opRegReg = 7'b0110011;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opSystem = 7'b1110011;

	// funct3 and funct7 fields
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [6:0] funct7Sub = 7'b0100000;
	localparam logic [11:0] ebreakFunct12 = 12'h001;

	// ALU operation select
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOr = 3'd3;
	localparam logic [2:0] aluXor = 3'd4;
	localparam logic [2:0] aluSlt = 3'd5;

endpackage

`default_nettype wire

// File: src/rvRegFile.sv
`timescale 1ns/1ns
`default_nettype none

module rvRegFile import rvPkg::*; (
	input  wire                    clock,
	input  wire                    reset,
	input  wire [regAddrWidth-1:0] readAddrA,
	input  wire [regAddrWidth-1:0] readAddrB,
	input  wire [regAddrWidth-1:0] writeAddr,
	input  wire                    writeEnable,
	input  wire [dataWidth-1:0]    writeData,
	output logic [dataWidth-1:0]   readDataA,
	output logic [dataWidth-1:0]   readDataB
);

	// x0 has no storage
	logic [dataWidth-1:0] regs [1:31];

	function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;
		// WB writes in the same cycle are seen by ID
		else if (writeEnable && addr == writeAddr)
			return writeData;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	always_comb begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

`default_nettype wire

// File: src/rvDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module rvDecoder import rvPkg::*; (
	input  wire [dataWidth-1:0]  instruction,
	output logic                 regWrite,
	output logic                 memRead,
	output logic                 memWrite,
	output logic                 memToReg,
	output logic                 aluSrc,
	output logic [2:0]           aluOp,
	output logic                 branch,
	output logic                 branchNotEqual,
	output logic                 jump,
	output logic                 halt,
	output logic [dataWidth-1:0] immediate
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [2:0] arithOp;
	logic [dataWidth-1:0] immI;
	logic [dataWidth-1:0] immS;
	logic [dataWidth-1:0] immB;
	logic [dataWidth-1:0] immJ;

	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];

	assign immI = {{20{instruction[31]}}, instruction[31:20]};
	assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
	assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
		instruction[30:25], instruction[11:8], 1'b0};
	assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
		instruction[20], instruction[30:21], 1'b0};

	// Same funct3 mapping for reg-reg and reg-imm forms
	always_comb begin
		case (funct3)
			f3Slt:   arithOp = aluSlt;
			f3Xor:   arithOp = aluXor;
			f3Or:    arithOp = aluOr;
			f3And:   arithOp = aluAnd;
			default: arithOp = aluAdd;
		endcase
	end

	always_comb begin
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		aluSrc = 1'b0;
		aluOp = aluAdd;
		branch = 1'b0;
		branchNotEqual = 1'b0;
		jump = 1'b0;
		halt = 1'b0;
		immediate = immI;
		case (opcode)
			opRegReg: begin
				regWrite = 1'b1;
				if (funct3 == f3AddSub && instruction[31:25] == funct7Sub)
					aluOp = aluSub;
				else
					aluOp = arithOp;
			end
			opImm: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = arithOp;
			end
			opLoad: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				memToReg = 1'b1;
				aluSrc = 1'b1;
			end
			opStore: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
				immediate = immS;
			end
			opBranch: begin
				// Only beq and bne, compared by subtraction
				branch = (funct3 == f3Beq) || (funct3 == f3Bne);
				branchNotEqual = (funct3 == f3Bne);
				aluOp = aluSub;
				immediate = immB;
			end
			opJal: begin
				regWrite = 1'b1;
				jump = 1'b1;
				immediate = immJ;
			end
			opSystem: begin
				halt = (funct3 == 3'b000) && (instruction[31:20] == ebreakFunct12);
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/rvAlu.sv
`timescale 1ns/1ns
`default_nettype none

module rvAlu import rvPkg::*; (
	input  wire [dataWidth-1:0]  operandA,
	input  wire [dataWidth-1:0]  operandB,
	input  wire [2:0]            aluOp,
	output logic [dataWidth-1:0] result,
	output logic                 zero
);

	logic lessThan;

	// Signed compare for slt
	assign lessThan = $signed(operandA) < $signed(operandB);

	always_comb begin
		case (aluOp)
			aluSub:  result = operandA - operandB;
			aluAnd:  result = operandA & operandB;
			aluOr:   result = operandA | operandB;
			aluXor:  result = operandA ^ operandB;
			aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
			default: result = operandA + operandB;
		endcase
	end

	// Equal operands after aluSub
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: src/rvCore.sv
`timescale 1ns/1ns
`default_nettype none

module rvCore import rvPkg::*; (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     run,
	output logic                    fetchRequest,
	output logic [memAddrWidth-1:0] fetchAddr,
	input  wire                     fetchReady,
	input  wire [dataWidth-1:0]     fetchData,
	output logic                    dataRequest,
	output logic                    dataWrite,
	output logic [memAddrWidth-1:0] dataAddr,
	output logic [dataWidth-1:0]    dataWriteData,
	input  wire                     dataReady,
	input  wire [dataWidth-1:0]     dataReadData,
	output logic                    halted
);

	// Fetch state
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] redirectPc;
	logic redirectValid;
	logic running;
	logic haltSeen;

	// IF/ID, an all-zero instruction is a bubble
	logic [dataWidth-1:0] ifIdInstr;
	logic [dataWidth-1:0] ifIdPc;
	logic [regAddrWidth-1:0] ifIdRs1;
	logic [regAddrWidth-1:0] ifIdRs2;

	// Decode results
	logic decRegWrite, decMemRead, decMemWrite, decMemToReg, decAluSrc;
	logic decBranch, decBranchNotEqual, decJump, decHalt;
	logic [2:0] decAluOp;
	logic [dataWidth-1:0] decImmediate;
	logic [dataWidth-1:0] rs1Data;
	logic [dataWidth-1:0] rs2Data;

	// ID/EX
	logic idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg;
	logic idExBranch, idExBranchNotEqual, idExJump, idExHalt, idExAluSrc;
	logic [2:0] idExAluOp;
	logic [dataWidth-1:0] idExPc, idExImm, idExRs1Data, idExRs2Data;
	logic [regAddrWidth-1:0] idExRs1, idExRs2, idExRd;

	// EX/MEM and MEM/WB
	logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg, exMemHalt;
	logic [dataWidth-1:0] exMemResult, exMemStoreData;
	logic [regAddrWidth-1:0] exMemRd;
	logic memWbRegWrite, memWbHalt;
	logic [dataWidth-1:0] memWbWriteData;
	logic [regAddrWidth-1:0] memWbRd;

	// EX datapath and hazard controls
	logic [dataWidth-1:0] forwardA, forwardB, aluOperandB, aluResult, exResult, branchTarget;
	logic aluZero;
	logic memWait, loadUse, flush;

	assign ifIdRs1 = ifIdInstr[19:15];
	assign ifIdRs2 = ifIdInstr[24:20];

	rvDecoder u_decoder (
		.instruction   (ifIdInstr),
		.regWrite      (decRegWrite),
		.memRead       (decMemRead),
		.memWrite      (decMemWrite),
		.memToReg      (decMemToReg),
		.aluSrc        (decAluSrc),
		.aluOp         (decAluOp),
		.branch        (decBranch),
		.branchNotEqual(decBranchNotEqual),
		.jump          (decJump),
		.halt          (decHalt),
		.immediate     (decImmediate)
	);

	rvRegFile u_regFile (
		.clock      (clock),
		.reset      (reset),
		.readAddrA  (ifIdRs1),
		.readAddrB  (ifIdRs2),
		.writeAddr  (memWbRd),
		.writeEnable(memWbRegWrite),
		.writeData  (memWbWriteData),
		.readDataA  (rs1Data),
		.readDataB  (rs2Data)
	);

	// Youngest producer wins
	function automatic logic [dataWidth-1:0] forwardOperand(
		input logic [regAddrWidth-1:0] rs,
		input logic [dataWidth-1:0] regValue
	);
		if (exMemRegWrite && exMemRd != '0 && exMemRd == rs)
			return exMemResult;
		else if (memWbRegWrite && memWbRd != '0 && memWbRd == rs)
			return memWbWriteData;
		else
			return regValue;
	endfunction

	always_comb begin
		forwardA = forwardOperand(idExRs1, idExRs1Data);
		forwardB = forwardOperand(idExRs2, idExRs2Data);
	end

	assign aluOperandB = idExAluSrc ? idExImm : forwardB;

	rvAlu u_alu (
		.operandA(forwardA),
		.operandB(aluOperandB),
		.aluOp   (idExAluOp),
		.result  (aluResult),
		.zero    (aluZero)
	);

	// jal links pc + 4
	assign exResult = idExJump ? idExPc + dataWidth'(4) : aluResult;
	assign branchTarget = idExPc + idExImm;

	assign memWait = (exMemMemRead || exMemMemWrite) && !dataReady;
	assign loadUse = idExMemRead && idExRd != '0 && (idExRd == ifIdRs1 || idExRd == ifIdRs2);
	assign flush = !memWait && (idExJump || (idExBranch && (aluZero ^ idExBranchNotEqual)));

	assign fetchRequest = running && !haltSeen;
	assign fetchAddr = pc[memAddrWidth+1:2];
	assign dataRequest = exMemMemRead || exMemMemWrite;
	assign dataWrite = exMemMemWrite;
	assign dataAddr = exMemResult[memAddrWidth+1:2];
	assign dataWriteData = exMemStoreData;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= resetPc;
			redirectValid <= 1'b0;
			running <= 1'b0;
			haltSeen <= 1'b0;
			halted <= 1'b0;
			ifIdInstr <= '0;
			{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <= '0;
			{idExBranch, idExBranchNotEqual, idExJump, idExHalt} <= '0;
			{exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg, exMemHalt} <= '0;
			{memWbRegWrite, memWbHalt} <= '0;
		end else begin
			running <= running || run;
			halted <= halted || memWbHalt;
			// Ebreak leaving ID ends fetching
			if (!memWait && !flush && !loadUse && !haltSeen && decHalt)
				haltSeen <= 1'b1;

			// A fetch already on the bus has to finish before the redirect
			if (flush) begin
				if (fetchRequest && !fetchReady)
					redirectValid <= 1'b1;
				else
					pc <= branchTarget;
			end else if (fetchReady && redirectValid) begin
				pc <= redirectPc;
				redirectValid <= 1'b0;
			end else if (fetchReady && !memWait && !loadUse) begin
				pc <= pc + dataWidth'(4);
			end

			// Words returned while IF/ID is held are fetched again
			if (!memWait && !loadUse) begin
				if (fetchReady && !redirectValid && !flush && !haltSeen)
					ifIdInstr <= fetchData;
				else
					ifIdInstr <= '0;
			end

			if (!memWait) begin
				if (flush || loadUse || haltSeen) begin
					{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <= '0;
					{idExBranch, idExBranchNotEqual, idExJump, idExHalt} <= '0;
				end else begin
					{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg} <=
						{decRegWrite, decMemRead, decMemWrite, decMemToReg};
					{idExBranch, idExBranchNotEqual, idExJump, idExHalt} <=
						{decBranch, decBranchNotEqual, decJump, decHalt};
				end
				{exMemRegWrite, exMemMemRead, exMemMemWrite, exMemMemToReg, exMemHalt} <=
					{idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg, idExHalt};
			end

			// Bubble into WB while the data access is pending
			if (memWait)
				{memWbRegWrite, memWbHalt} <= '0;
			else
				{memWbRegWrite, memWbHalt} <= {exMemRegWrite, exMemHalt};
		end
	end

	always_ff @(posedge clock) begin
		if (flush)
			redirectPc <= branchTarget;
		if (!memWait && !loadUse)
			ifIdPc <= pc;
		if (memWait) begin
			// Keep values forwarded from WB before that stage drains
			idExRs1Data <= forwardA;
			idExRs2Data <= forwardB;
		end else begin
			idExPc <= ifIdPc;
			idExImm <= decImmediate;
			idExRs1Data <= rs1Data;
			idExRs2Data <= rs2Data;
			idExRs1 <= ifIdRs1;
			idExRs2 <= ifIdRs2;
			idExRd <= ifIdInstr[11:7];
			idExAluSrc <= decAluSrc;
			idExAluOp <= decAluOp;
			exMemResult <= exResult;
			exMemStoreData <= forwardB;
			exMemRd <= idExRd;
		end
		memWbWriteData <= exMemMemToReg ? dataReadData : exMemResult;
		memWbRd <= exMemRd;
	end

endmodule

`default_nettype wire

// File: src/memArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module memArbiter import rvPkg::*; (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     hostRequest,
	input  wire                     hostWrite,
	input  wire [memAddrWidth-1:0]  hostAddr,
	input  wire [dataWidth-1:0]     hostWriteData,
	output logic                    hostReady,
	output logic [dataWidth-1:0]    hostReadData,
	input  wire                     fetchRequest,
	input  wire [memAddrWidth-1:0]  fetchAddr,
	output logic                    fetchReady,
	output logic [dataWidth-1:0]    fetchData,
	input  wire                     dataRequest,
	input  wire                     dataWrite,
	input  wire [memAddrWidth-1:0]  dataAddr,
	input  wire [dataWidth-1:0]     dataWriteData,
	output logic                    dataReady,
	output logic [dataWidth-1:0]    dataReadData,
	output logic                    memEnable,
	output logic                    memWrite,
	output logic [memAddrWidth-1:0] memAddr,
	output logic [dataWidth-1:0]    memWriteData,
	input  wire [dataWidth-1:0]     memReadData
);

	logic grantHost;
	logic grantData;
	logic grantFetch;

	// In its ready cycle a requester still shows the finished request
	assign grantHost = hostRequest && !hostReady;
	assign grantData = dataRequest && !dataReady && !grantHost;
	assign grantFetch = fetchRequest && !fetchReady && !grantHost && !grantData;

	always_comb begin
		memEnable = grantHost || grantData || grantFetch;
		memWrite = 1'b0;
		memAddr = fetchAddr;
		memWriteData = '0;
		if (grantHost) begin
			memWrite = hostWrite;
			memAddr = hostAddr;
			memWriteData = hostWriteData;
		end else if (grantData) begin
			memWrite = dataWrite;
			memAddr = dataAddr;
			memWriteData = dataWriteData;
		end
	end

	// Ready registers hold the winner of the access in flight
	always_ff @(posedge clock or negedge reset) begin
		if (!reset)
			{hostReady, dataReady, fetchReady} <= '0;
		else
			{hostReady, dataReady, fetchReady} <= {grantHost, grantData, grantFetch};
	end

	assign hostReadData = hostReady ? memReadData : '0;
	assign dataReadData = dataReady ? memReadData : '0;
	assign fetchData = fetchReady ? memReadData : '0;

endmodule

`default_nettype wire

// File: src/sharedMemory.sv
`timescale 1ns/1ns
`default_nettype none

module sharedMemory import rvPkg::*; (
	input  wire                    clock,
	input  wire                    enable,
	input  wire                    write,
	input  wire [memAddrWidth-1:0] addr,
	input  wire [dataWidth-1:0]    writeData,
	output logic [dataWidth-1:0]   readData
);

	logic [dataWidth-1:0] words [0:memDepth-1];

	// Single port, read returns the old word on a write
	always_ff @(posedge clock) begin
		if (enable) begin
			if (write)
				words[addr] <= writeData;
			readData <= words[addr];
		end
	end

endmodule

`default_nettype wire

// File: src/rvSystem.sv
`timescale 1ns/1ns
`default_nettype none

module rvSystem import rvPkg::*; (
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    run,
	input  wire                    hostRequest,
	input  wire                    hostWrite,
	input  wire [memAddrWidth-1:0] hostAddr,
	input  wire [dataWidth-1:0]    hostWriteData,
	output logic                   hostReady,
	output logic [dataWidth-1:0]   hostReadData,
	output logic                   halted
);

	logic fetchRequest;
	logic fetchReady;
	logic [memAddrWidth-1:0] fetchAddr;
	logic [dataWidth-1:0] fetchData;
	logic dataRequest;
	logic dataWrite;
	logic dataReady;
	logic [memAddrWidth-1:0] dataAddr;
	logic [dataWidth-1:0] dataWriteData;
	logic [dataWidth-1:0] dataReadData;
	logic memEnable;
	logic memWrite;
	logic [memAddrWidth-1:0] memAddr;
	logic [dataWidth-1:0] memWriteData;
	logic [dataWidth-1:0] memReadData;

	rvCore u_core (
		.clock        (clock),
		.reset        (reset),
		.run          (run),
		.fetchRequest (fetchRequest),
		.fetchAddr    (fetchAddr),
		.fetchReady   (fetchReady),
		.fetchData    (fetchData),
		.dataRequest  (dataRequest),
		.dataWrite    (dataWrite),
		.dataAddr     (dataAddr),
		.dataWriteData(dataWriteData),
		.dataReady    (dataReady),
		.dataReadData (dataReadData),
		.halted       (halted)
	);

	// Host outranks data, data outranks fetch
	memArbiter u_arbiter (
		.clock        (clock),
		.reset        (reset),
		.hostRequest  (hostRequest),
		.hostWrite    (hostWrite),
		.hostAddr     (hostAddr),
		.hostWriteData(hostWriteData),
		.hostReady    (hostReady),
		.hostReadData (hostReadData),
		.fetchRequest (fetchRequest),
		.fetchAddr    (fetchAddr),
		.fetchReady   (fetchReady),
		.fetchData    (fetchData),
		.dataRequest  (dataRequest),
		.dataWrite    (dataWrite),
		.dataAddr     (dataAddr),
		.dataWriteData(dataWriteData),
		.dataReady    (dataReady),
		.dataReadData (dataReadData),
		.memEnable    (memEnable),
		.memWrite     (memWrite),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.memReadData  (memReadData)
	);

	sharedMemory u_memory (
		.clock    (clock),
		.enable   (memEnable),
		.write    (memWrite),
		.addr     (memAddr),
		.writeData(memWriteData),
		.readData (memReadData)
	);

endmodule

`default_nettype wire

// File: tb/rvSystemTb.sv
`timescale 1ns/1ns
`default_nettype none

module rvSystemTb import rvPkg::*; ();

	localparam int clockPeriod = 40;
	localparam int resetCycles = 4;
	localparam int maxRecords = 64;
	// Ready seen at the second falling edge after the request is raised
	localparam int hostLatency = 2;
	localparam int readyLimit = 8;
	// Budget per record, covers loading, execution and readback
	localparam int cyclesPerRecord = 30;

	// Record kinds in the vector file
	localparam int kindLoad = 0;
	localparam int kindRun = 1;
	localparam int kindExpect = 2;

	logic clock;
	logic reset;
	logic run;
	logic hostRequest;
	logic hostWrite;
	logic [memAddrWidth-1:0] hostAddr;
	logic [dataWidth-1:0] hostWriteData;
	logic hostReady;
	logic [dataWidth-1:0] hostReadData;
	logic halted;

	logic [dataWidth-1:0] vectors [0:3*maxRecords-1];
	logic [dataWidth-1:0] expectedWord [0:memDepth-1];
	bit tracked [0:memDepth-1];
	int recordCount;
	int checkCount;
	bit vectorsLoaded;
	bit sawRun;

	rvSystem u_dut (
		.clock        (clock),
		.reset        (reset),
		.run          (run),
		.hostRequest  (hostRequest),
		.hostWrite    (hostWrite),
		.hostAddr     (hostAddr),
		.hostWriteData(hostWriteData),
		.hostReady    (hostReady),
		.hostReadData (hostReadData),
		.halted       (halted)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	task automatic reportMismatch(input string name, input logic [dataWidth-1:0] expected,
		input logic [dataWidth-1:0] actual);
		$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic abortRun(input string reason);
		$display("ERROR: %s", reason);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	// One host access, held until the ready pulse and dropped on the next edge
	task automatic hostAccess(input logic write, input logic [memAddrWidth-1:0] addr,
		input logic [dataWidth-1:0] writeWord, output logic [dataWidth-1:0] readWord);
		int cycles;
		cycles = 0;
		@(posedge clock);
		hostRequest <= 1'b1;
		hostWrite <= write;
		hostAddr <= addr;
		hostWriteData <= writeWord;
		do begin
			@(negedge clock);
			cycles++;
		end while (!hostReady && cycles < readyLimit);
		assert (hostReady === 1'b1)
		else abortRun($sformatf("hostReady never pulsed for the access to 0x%02h", addr));
		assert (cycles == hostLatency)
		else reportMismatch("hostReady latency", hostLatency, cycles);
		readWord = hostReadData;
		@(posedge clock);
		hostRequest <= 1'b0;
		hostWrite <= 1'b0;
	endtask

	// Read back every address the vectors know about
	task automatic verifyTracked();
		logic [dataWidth-1:0] readWord;
		for (int a = 0; a < memDepth; a++) begin
			if (tracked[a]) begin
				hostAccess(1'b0, memAddrWidth'(a), '0, readWord);
				assert (readWord === expectedWord[a])
				else reportMismatch($sformatf("hostReadData[0x%02h]", a), expectedWord[a], readWord);
				checkCount++;
			end
		end
	endtask

	task automatic startProgram();
		// Image must read back intact while the core is idle
		verifyTracked();
		@(posedge clock);
		run <= 1'b1;
		sawRun = 1'b1;
		do begin
			@(negedge clock);
		end while (halted !== 1'b1);
	endtask

	initial begin
		logic [dataWidth-1:0] kind;
		logic [dataWidth-1:0] addrWord;
		logic [dataWidth-1:0] data;
		logic [dataWidth-1:0] readWord;
		reset = 1'b0;
		run = 1'b0;
		hostRequest = 1'b0;
		hostWrite = 1'b0;
		hostAddr = '0;
		hostWriteData = '0;
		checkCount = 0;
		sawRun = 1'b0;
		vectorsLoaded = 1'b0;
		for (int a = 0; a < memDepth; a++)
			tracked[a] = 1'b0;

		$readmemh("tb/programVectors.txt", vectors);
		recordCount = 0;
		while (recordCount < maxRecords && !$isunknown(vectors[3*recordCount]))
			recordCount++;
		vectorsLoaded = 1'b1;
		assert (recordCount > 0)
		else abortRun("the vector file holds no records");

		repeat (resetCycles) @(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		assert (halted === 1'b0)
		else reportMismatch("halted", 1'b0, halted);
		assert (hostReady === 1'b0)
		else reportMismatch("hostReady", 1'b0, hostReady);

		for (int i = 0; i < recordCount; i++) begin
			kind = vectors[3*i];
			addrWord = vectors[3*i+1];
			data = vectors[3*i+2];
			case (kind)
				kindLoad: begin
					hostAccess(1'b1, addrWord[memAddrWidth-1:0], data, readWord);
					expectedWord[addrWord[memAddrWidth-1:0]] = data;
					tracked[addrWord[memAddrWidth-1:0]] = 1'b1;
				end
				kindRun: startProgram();
				kindExpect: begin
					// Replaces the preloaded value, checked in the final sweep
					expectedWord[addrWord[memAddrWidth-1:0]] = data;
					tracked[addrWord[memAddrWidth-1:0]] = 1'b1;
				end
				default: abortRun($sformatf("record %0d has unknown kind %h", i, kind));
			endcase
		end

		// Results, untouched markers and the program image after halt
		verifyTracked();

		if (sawRun && checkCount > 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abortRun("the vectors never started the core or no word was checked");
		end
	end

	// Watchdog sized from the number of records
	initial begin
		int watchdogCycles;
		wait (vectorsLoaded);
		watchdogCycles = resetCycles + recordCount * cyclesPerRecord;
		#(watchdogCycles * clockPeriod);
		if (halted === 1'b1)
			abortRun("timeout, host readback after halt did not finish");
		else
			abortRun("timeout, halted never rose after run");
	end

endmodule

`default_nettype wire

// File: tb/programVectors.txt
// Columns: kind, word address, data (hex)
// Kind 0 host write, 1 raise run and wait for halt, 2 expected word after halt
0 00 01700093 // addi x1, x0, 23
0 01 FF900113 // addi x2, x0, -7
0 02 002081B3 // add  x3, x1, x2
0 03 40118233 // sub  x4, x3, x1
0 04 001272B3 // and  x5, x4, x1
0 05 0022E333 // or   x6, x5, x2
0 06 001343B3 // xor  x7, x6, x1
0 07 00112433 // slt  x8, x2, x1
0 08 0020A4B3 // slt  x9, x1, x2
0 09 10302023 // sw x3, 256(x0)
0 0A 10402223 // sw x4, 260(x0)
0 0B 10502423 // sw x5, 264(x0)
0 0C 10602623 // sw x6, 268(x0)
0 0D 10702823 // sw x7, 272(x0)
0 0E 10802A23 // sw x8, 276(x0)
0 0F 10902C23 // sw x9, 280(x0)
0 10 14002503 // lw  x10, 320(x0)
0 11 001505B3 // add x11, x10, x1
0 12 10B02E23 // sw  x11, 284(x0)
0 13 00108463 // beq x1, x1, +8 taken
0 14 12102023 // sw x1, 288(x0) skipped
0 15 00209463 // bne x1, x2, +8 taken
0 16 12102223 // sw x1, 292(x0) skipped
0 17 00208463 // beq x1, x2, +8 not taken
0 18 12102423 // sw x1, 296(x0)
0 19 00109463 // bne x1, x1, +8 not taken
0 1A 12202623 // sw x2, 300(x0)
0 1B 00C0066F // jal x12, +12
0 1C 12102823 // sw x1, 304(x0) skipped
0 1D 12102A23 // sw x1, 308(x0) skipped
0 1E 12C02C23 // sw x12, 312(x0)
0 1F 00100073 // ebreak
0 50 00001234 // load operand
0 48 DEAD0048 // markers for the flushed stores
0 49 DEAD0049
0 4C DEAD004C
0 4D DEAD004D
1 00 00000000
2 40 00000010 // 23 + -7
2 41 FFFFFFF9 // 16 - 23
2 42 00000011
2 43 FFFFFFF9
2 44 FFFFFFEE
2 45 00000001 // -7 < 23 signed
2 46 00000000
2 47 0000124B // 0x1234 + 23
2 4A 00000017
2 4B FFFFFFF9
2 4E 00000070 // jal link, pc 0x6C + 4

// File: list.f
src/rvPkg.sv
src/rvRegFile.sv
src/rvDecoder.sv
src/rvAlu.sv
src/rvCore.sv
src/memArbiter.sv
src/sharedMemory.sv
src/rvSystem.sv
tb/rvSystemTb.sv
